/* logic/softex_pkg.sv */
/* bfloat16 only (1/8/7, bias 127). NaN and infinity have no special encoding here.
   The sum is unsigned Q16.16 and the count wraps at 2^COUNT_WIDTH. */

package softex_pkg;

    // ************************************************************
    // bfloat16 format
    // ************************************************************

    localparam int unsigned BF16_WIDTH = 16;
    localparam int unsigned EXP_BITS   = 8;
    localparam int unsigned MAN_BITS   = 7;
    localparam int unsigned BIAS       = 127;

    // ************************************************************
    // Schraudolph defaults
    // ************************************************************

    localparam int unsigned EXPU_A_FRACTION       = 14;   // Fraction bits of 1/ln 2
    localparam logic        EXPU_ENABLE_ROUNDING  = 1'b1;

    // ************************************************************
    // Accumulator widths
    // ************************************************************

    localparam int unsigned SUM_WIDTH   = 32;   // Q16.16
    localparam int unsigned COUNT_WIDTH = 16;

    typedef struct packed {
        logic                  sign;
        logic [EXP_BITS-1:0]   exponent;
        logic [MAN_BITS-1:0]   mantissa;
    } bf16_fields_t;

    // Same word seen either as a plain vector or split into fields
    typedef union packed {
        logic [BF16_WIDTH-1:0] raw;
        bf16_fields_t          fields;
    } bf16_u;

endpackage

/* logic/expu_reg_pkg.sv */
/* Register map of the exponential unit. Four word addresses, 32-bit data.
   A write of any data to ADDR_SUM clears the sum, the count and the overflow flag. */

package expu_reg_pkg;

    localparam int unsigned REG_ADDR_WIDTH = 2;
    localparam int unsigned REG_DATA_WIDTH = 32;

    // ************************************************************
    // Addresses
    // ************************************************************

    localparam logic [REG_ADDR_WIDTH-1:0] ADDR_CTRL   = 2'd0;
    localparam logic [REG_ADDR_WIDTH-1:0] ADDR_SUM    = 2'd1;
    localparam logic [REG_ADDR_WIDTH-1:0] ADDR_STATUS = 2'd2;

    // ************************************************************
    // Bit positions
    // ************************************************************

    localparam int unsigned CTRL_ACC_EN_BIT = 0;    // Accumulate enable

    // Count sits in the low bits of the status word
    localparam int unsigned STATUS_OVFL_BIT = 16;   // Sticky sum overflow

endpackage

/* logic/expu_schraudolph.sv */
/* Approximate e^x on bfloat16 by the Schraudolph method. Purely combinational.
   Large inputs saturate to exponent all ones (positive) or to zero (negative). */

module expu_schraudolph
    import softex_pkg::*;
#(
    parameter int unsigned A_FRACTION      = EXPU_A_FRACTION,
    parameter logic        ENABLE_ROUNDING = EXPU_ENABLE_ROUNDING
) (
    input  logic [BF16_WIDTH-1:0] op,
    output logic [BF16_WIDTH-1:0] res
);

    localparam real         A_REAL     = 1.0 / $ln(2.0);
    localparam int unsigned A_INT_BITS = $clog2(int'(A_REAL)) + 1;
    localparam int unsigned A_WIDTH    = A_INT_BITS + A_FRACTION;

    // Largest input exponent that still fits the result exponent
    localparam int unsigned MAX_EXP  = BIAS + EXP_BITS - (A_INT_BITS + 1);
    localparam int unsigned PROD_MSB = MAN_BITS + A_FRACTION + A_INT_BITS;

    // 1/ln 2 in Q<A_INT_BITS>.<A_FRACTION>
    localparam logic [A_WIDTH-1:0] A = (A_WIDTH)'(int'(A_REAL * 2.0 ** A_FRACTION));

    bf16_u op_u;
    bf16_u res_u;

    logic [MAN_BITS:0]            significand;   // Q1.7
    logic [PROD_MSB:0]            product;
    logic [EXP_BITS-1:0]          shamt;
    logic [EXP_BITS+MAN_BITS:0]   shifted;       // One extra bit for rounding
    logic [EXP_BITS+MAN_BITS-1:0] rounded;
    logic [EXP_BITS+MAN_BITS-1:0] signed_val;
    logic                         ovfr;

    assign op_u.raw    = op;
    assign significand = {1'b1, op_u.fields.mantissa};

    assign product = significand * A;

    // Wraps when the exponent is above MAX_EXP, but then ovfr takes over
    assign shamt   = (EXP_BITS)'(MAX_EXP) - op_u.fields.exponent;
    assign shifted = product[PROD_MSB : A_FRACTION - MAN_BITS] >> shamt;

    assign rounded = shifted[EXP_BITS+MAN_BITS:1] + (ENABLE_ROUNDING ? shifted[0] : 1'b0);

    assign signed_val = op_u.fields.sign ? -rounded : rounded;

    always_comb begin
        ovfr = 1'b0;
        if (op_u.fields.exponent > MAX_EXP) begin
            ovfr = 1'b1;
        end else if (op_u.fields.exponent == MAX_EXP) begin
            // Integer part too wide for the exponent field
            ovfr = product[PROD_MSB] ||
                   (op_u.fields.sign && (&product[PROD_MSB-1 -: EXP_BITS]));
        end
    end

    // ************************************************************
    // Reinterpret the fixed-point value as exponent and mantissa
    // ************************************************************

    always_comb begin
        res_u.fields.sign = 1'b0;   // e^x is never negative
        if (!ovfr) begin
            res_u.fields.exponent = signed_val[EXP_BITS+MAN_BITS-1 : MAN_BITS] + (EXP_BITS)'(BIAS);
            res_u.fields.mantissa = signed_val[MAN_BITS-1:0];
        end else begin
            res_u.fields.exponent = op_u.fields.sign ? '0 : '1;
            res_u.fields.mantissa = '0;
        end
    end

    assign res = res_u.raw;

endmodule

/* logic/expu_regfile.sv */
/* Control, clear and readback registers. Reads are combinational.
   The clear strobe follows the write to ADDR_SUM in the same cycle. */

module expu_regfile
    import softex_pkg::*;
    import expu_reg_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,

    input  logic                      reg_write,
    input  logic [REG_ADDR_WIDTH-1:0] reg_addr,
    input  logic [REG_DATA_WIDTH-1:0] reg_wdata,
    output logic [REG_DATA_WIDTH-1:0] reg_rdata,

    input  logic [SUM_WIDTH-1:0]      sum,
    input  logic [COUNT_WIDTH-1:0]    count,
    input  logic                      ovfl,

    output logic                      acc_en,
    output logic                      acc_clear
);

    logic [REG_DATA_WIDTH-1:0] ctrl_word;
    logic [REG_DATA_WIDTH-1:0] status_word;

    // ************************************************************
    // Control register and clear strobe
    // ************************************************************

    always_ff @(posedge clk) begin
        if (rst) begin
            acc_en <= 1'b0;
        end else if (reg_write && (reg_addr == ADDR_CTRL)) begin
            acc_en <= reg_wdata[CTRL_ACC_EN_BIT];
        end
    end

    // Data is ignored, any write to the sum clears it
    assign acc_clear = reg_write && (reg_addr == ADDR_SUM);

    // ************************************************************
    // Read mux
    // ************************************************************

    always_comb begin
        ctrl_word                  = '0;
        ctrl_word[CTRL_ACC_EN_BIT] = acc_en;

        status_word                  = '0;
        status_word[COUNT_WIDTH-1:0] = count;
        status_word[STATUS_OVFL_BIT] = ovfl;
    end

    always_comb begin
        case (reg_addr)
            ADDR_CTRL:   reg_rdata = ctrl_word;
            ADDR_SUM:    reg_rdata = (REG_DATA_WIDTH)'(sum);
            ADDR_STATUS: reg_rdata = status_word;
            default:     reg_rdata = '0;   // Unmapped
        endcase
    end

endmodule

/* logic/expu_accumulator.sv */
/* Running Q16.16 sum of positive bfloat16 results, saturating at all ones.
   The sign of the input is ignored. The clear wins over an accumulate in the same cycle. */

module expu_accumulator
    import softex_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,

    input  logic                   res_valid,
    input  logic [BF16_WIDTH-1:0]  res,

    input  logic                   acc_en,
    input  logic                   acc_clear,

    output logic [SUM_WIDTH-1:0]   sum,
    output logic [COUNT_WIDTH-1:0] count,
    output logic                   ovfl
);

    localparam int unsigned FRAC_BITS = SUM_WIDTH / 2;

    // Left shift of the Q1.7 significand is exponent - SHIFT_OFFSET
    localparam int unsigned SHIFT_OFFSET = BIAS + MAN_BITS - FRAC_BITS;

    // From here on the value no longer fits the integer part
    localparam int unsigned SAT_EXP = BIAS + SUM_WIDTH - FRAC_BITS;

    localparam int unsigned SHAMT_WIDTH = EXP_BITS + 2;

    bf16_u                  res_u;
    logic [MAN_BITS:0]      significand;
    logic [SHAMT_WIDTH-1:0] shamt;
    logic [SHAMT_WIDTH-1:0] rshamt;
    logic [SUM_WIDTH-1:0]   conv;
    logic [SUM_WIDTH:0]     sum_ext;
    logic                   accumulate;

    assign res_u.raw   = res;
    assign significand = {1'b1, res_u.fields.mantissa};

    // ************************************************************
    // bfloat16 to Q16.16
    // ************************************************************

    // Two's complement difference, MSB set means a right shift
    assign shamt  = {2'b00, res_u.fields.exponent} - (SHAMT_WIDTH)'(SHIFT_OFFSET);
    assign rshamt = -shamt;

    always_comb begin
        if (res_u.fields.exponent == '0) begin
            conv = '0;
        end else if (res_u.fields.exponent >= SAT_EXP) begin
            conv = '1;
        end else if (shamt[SHAMT_WIDTH-1]) begin
            conv = (SUM_WIDTH)'(significand) >> rshamt;
        end else begin
            conv = (SUM_WIDTH)'(significand) << shamt;
        end
    end

    // ************************************************************
    // Saturating sum and counter
    // ************************************************************

    assign sum_ext    = {1'b0, sum} + {1'b0, conv};   // Carry out flags saturation
    assign accumulate = res_valid && acc_en;

    always_ff @(posedge clk) begin
        if (rst) begin
            sum   <= '0;
            count <= '0;
            ovfl  <= 1'b0;
        end else if (acc_clear) begin
            sum   <= '0;
            count <= '0;
            ovfl  <= 1'b0;
        end else if (accumulate) begin
            sum   <= sum_ext[SUM_WIDTH] ? '1 : sum_ext[SUM_WIDTH-1:0];
            ovfl  <= ovfl | sum_ext[SUM_WIDTH];
            count <= count + 1'b1;   // Wraps
        end
    end

endmodule

/* logic/expu_top.sv */
/* Two-stage exponential pipeline plus softmax denominator accumulator.
   No back-pressure: a result leaves exactly 2 cycles after its input strobe. */

module expu_top
    import softex_pkg::*;
    import expu_reg_pkg::*;
#(
    parameter int unsigned A_FRACTION      = EXPU_A_FRACTION,
    parameter logic        ENABLE_ROUNDING = EXPU_ENABLE_ROUNDING
) (
    input  logic                      clk,
    input  logic                      rst,

    input  logic                      in_valid,
    input  logic [BF16_WIDTH-1:0]     in_op,
    output logic                      out_valid,
    output logic [BF16_WIDTH-1:0]     out_res,

    input  logic                      reg_write,
    input  logic [REG_ADDR_WIDTH-1:0] reg_addr,
    input  logic [REG_DATA_WIDTH-1:0] reg_wdata,
    output logic [REG_DATA_WIDTH-1:0] reg_rdata
);

    logic                   in_valid_q;
    logic [BF16_WIDTH-1:0]  in_op_q;
    logic [BF16_WIDTH-1:0]  exp_res;

    logic                   acc_en;
    logic                   acc_clear;
    logic [SUM_WIDTH-1:0]   sum;
    logic [COUNT_WIDTH-1:0] count;
    logic                   ovfl;

    // ************************************************************
    // Pipeline
    // ************************************************************

    always_ff @(posedge clk) begin
        if (rst) begin
            in_valid_q <= 1'b0;
            out_valid  <= 1'b0;
        end else begin
            in_valid_q <= in_valid;
            out_valid  <= in_valid_q;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) in_op_q <= in_op;
        if (in_valid_q) out_res <= exp_res;
    end

    expu_schraudolph #(
        .A_FRACTION      (A_FRACTION),
        .ENABLE_ROUNDING (ENABLE_ROUNDING)
    ) u_schraudolph (
        .op  (in_op_q),
        .res (exp_res)
    );

    expu_accumulator u_accumulator (
        .clk       (clk),
        .rst       (rst),
        .res_valid (out_valid),
        .res       (out_res),
        .acc_en    (acc_en),
        .acc_clear (acc_clear),
        .sum       (sum),
        .count     (count),
        .ovfl      (ovfl)
    );

    expu_regfile u_regfile (
        .clk       (clk),
        .rst       (rst),
        .reg_write (reg_write),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata),
        .reg_rdata (reg_rdata),
        .sum       (sum),
        .count     (count),
        .ovfl      (ovfl),
        .acc_en    (acc_en),
        .acc_clear (acc_clear)
    );

endmodule

/* bench/expu_assertions.sv */
/* Timing and invariant checks for expu_top. Inactive while rst is high.
   fail_count holds the number of assertion failures seen so far. */

module expu_assertions
    import softex_pkg::*;
(
    input logic                  clk,
    input logic                  rst,
    input logic                  in_valid,
    input logic                  out_valid,
    input logic [BF16_WIDTH-1:0] out_res,
    input logic [SUM_WIDTH-1:0]  sum,
    input logic                  acc_clear
);

    timeunit 1ns;
    timeprecision 1ps;

    int unsigned fail_count = 0;

    // Input register plus output register
    latency_two: assert property (@(posedge clk) disable iff (rst)
        out_valid == $past(in_valid, 2))
    else begin
        fail_count++;
        $error("out_valid does not follow in_valid by exactly 2 cycles");
    end

    result_positive: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> !out_res[BF16_WIDTH-1])
    else begin
        fail_count++;
        $error("out_res has its sign bit set while out_valid is high");
    end

    // Only a clear may lower the sum
    sum_monotonic: assert property (@(posedge clk) disable iff (rst)
        !$past(acc_clear) |-> (sum >= $past(sum)))
    else begin
        fail_count++;
        $error("sum decreased without acc_clear");
    end

endmodule

bind expu_top expu_assertions u_assertions (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .out_valid (out_valid),
    .out_res   (out_res),
    .sum       (sum),
    .acc_clear (acc_clear)
);

/* bench/expu_tb.sv */
/* Self-checking testbench for expu_top with its default parameters.
   Stops at the first mismatch. The reference model covers the default A_FRACTION only. */

module expu_tb
    import softex_pkg::*;
    import expu_reg_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_TBL   = 18;
    localparam int N_RAND  = 200;
    localparam int N_IDLE  = 8;
    localparam int N_OVFL  = 6;
    localparam int TIMEOUT = N_TBL + N_RAND + 200;

    localparam int MAX_EXP_M = BIAS + 6;
    localparam int A_MODEL   = $rtoi(1.4426950408889634 * (2.0 ** EXPU_A_FRACTION) + 0.5);

    logic                      clk;
    logic                      rst;
    logic                      in_valid;
    logic [BF16_WIDTH-1:0]     in_op;
    logic                      out_valid;
    logic [BF16_WIDTH-1:0]     out_res;
    logic                      reg_write;
    logic [REG_ADDR_WIDTH-1:0] reg_addr;
    logic [REG_DATA_WIDTH-1:0] reg_wdata;
    logic [REG_DATA_WIDTH-1:0] reg_rdata;

    // 0, 1, -1, 2.5, small values, exponent 0, the MAX_EXP edge, then large inputs
    logic [BF16_WIDTH-1:0] tbl_op [N_TBL] = '{
        16'h0000, 16'h3f80, 16'hbf80, 16'h4020, 16'h3c00, 16'hbc00,
        16'h3a80, 16'h0040, 16'h8001, 16'h4280, 16'hc280, 16'h42b1,
        16'hc2b1, 16'h42ff, 16'h4300, 16'hc300, 16'h7f00, 16'hff00
    };
    logic [BF16_WIDTH-1:0] tbl_exp [N_TBL];

    logic [BF16_WIDTH-1:0] exp_q[$];   // Expected results in order
    int                    due_q[$];   // Cycle at which each one is due

    int                     cycle = 0;
    logic [31:0]            lfsr;
    logic                   acc_on;
    logic [SUM_WIDTH-1:0]   sum_m;
    logic [COUNT_WIDTH-1:0] count_m;
    logic                   ovfl_m;
    logic [BF16_WIDTH-1:0]  op;

    expu_top u_dut (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_op     (in_op),
        .out_valid (out_valid),
        .out_res   (out_res),
        .reg_write (reg_write),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata),
        .reg_rdata (reg_rdata)
    );

    always #2 clk = ~clk;

    // ************************************************************
    // Reference model
    // ************************************************************

    function automatic logic [BF16_WIDTH-1:0] exp_model(input logic [BF16_WIDTH-1:0] x);
        logic        sgn;
        int          e;
        logic [31:0] prod;
        logic [31:0] v;
        logic [31:0] r;
        logic [31:0] s;
        logic [7:0]  res_e;
        sgn  = x[15];
        e    = int'(x[14:7]);
        prod = 32'(A_MODEL) * {24'd0, 1'b1, x[6:0]};   // 23 bits wide
        if ((e > MAX_EXP_M) ||
            (e == MAX_EXP_M && (prod[22] || (sgn && (prod[21:14] == 8'hff))))) begin
            return sgn ? 16'h0000 : 16'h7f80;
        end
        v = (prod >> (EXPU_A_FRACTION - MAN_BITS)) >> (MAX_EXP_M - e);
        r = ((v >> 1) + (EXPU_ENABLE_ROUNDING ? {31'd0, v[0]} : 32'd0)) & 32'h7fff;
        s = sgn ? ((~r + 32'd1) & 32'h7fff) : r;
        res_e = s[14:7] + 8'(BIAS);
        return {1'b0, res_e, s[6:0]};
    endfunction

    function automatic logic [SUM_WIDTH-1:0] to_q16(input logic [BF16_WIDTH-1:0] x);
        int          e;
        int          sh;
        logic [31:0] sig;
        e   = int'(x[14:7]);
        sig = {24'd0, 1'b1, x[6:0]};
        sh  = e - int'(BIAS) + 9;
        if (e == 0) return '0;
        if (e >= int'(BIAS) + 16) return '1;
        if (sh >= 0) return sig << sh;
        return sig >> (-sh);
    endfunction

    function automatic logic [15:0] lfsr_bits(input int n);
        logic [15:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val  = {val[14:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return val;
    endfunction

    // |x| below 4 keeps the sum of 200 results well inside Q16.16
    function automatic logic [BF16_WIDTH-1:0] random_op();
        logic [15:0] sgn;
        logic [15:0] e;
        logic [15:0] m;
        sgn = lfsr_bits(1);
        e   = lfsr_bits(3);
        m   = lfsr_bits(7);
        return {sgn[0], 8'd121 + e[7:0], m[6:0]};
    endfunction

    task automatic mirror_add(input logic [BF16_WIDTH-1:0] r);
        logic [SUM_WIDTH:0] t;
        t = {1'b0, sum_m} + {1'b0, to_q16(r)};
        if (t[SUM_WIDTH]) begin
            sum_m  = '1;
            ovfl_m = 1'b1;
        end else begin
            sum_m = t[SUM_WIDTH-1:0];
        end
        count_m = count_m + 1'b1;
    endtask

    // ************************************************************
    // Checks and bus tasks
    // ************************************************************

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1, "run stopped at cycle %0d", cycle);
    endtask

    task automatic check_res(input string name, input logic [BF16_WIDTH-1:0] got,
                             input logic [BF16_WIDTH-1:0] expected);
        if (got !== expected)
            stop_with_failure($sformatf("mismatch %s: got 0x%h, expected 0x%h",
                                        name, got, expected));
    endtask

    task automatic check_word(input string name, input logic [REG_DATA_WIDTH-1:0] got,
                              input logic [REG_DATA_WIDTH-1:0] expected);
        if (got !== expected)
            stop_with_failure($sformatf("mismatch %s: got 0x%h, expected 0x%h",
                                        name, got, expected));
    endtask

    task automatic write_reg(input logic [REG_ADDR_WIDTH-1:0] a,
                             input logic [REG_DATA_WIDTH-1:0] d);
        @(negedge clk);
        reg_write = 1'b1;
        reg_addr  = a;
        reg_wdata = d;
        if (a == ADDR_CTRL) acc_on = d[CTRL_ACC_EN_BIT];
        if (a == ADDR_SUM) begin
            sum_m   = '0;
            count_m = '0;
            ovfl_m  = 1'b0;
        end
        @(negedge clk);
        reg_write = 1'b0;
        reg_wdata = '0;
    endtask

    task automatic check_reg(input string name, input logic [REG_ADDR_WIDTH-1:0] a,
                             input logic [REG_DATA_WIDTH-1:0] expected);
        @(negedge clk);
        reg_addr = a;
        #1;   // Combinational read
        check_word(name, reg_rdata, expected);
    endtask

    task automatic send_op(input logic [BF16_WIDTH-1:0] x, input logic [BF16_WIDTH-1:0] e);
        @(negedge clk);
        in_valid = 1'b1;
        in_op    = x;
        exp_q.push_back(e);
        due_q.push_back(cycle + 2);
    endtask

    task automatic finish_stream();
        @(negedge clk);
        in_valid = 1'b0;
        in_op    = '0;
        while (exp_q.size() != 0) @(negedge clk);
        @(negedge clk);   // Last result reaches the sum
    endtask

    // ************************************************************
    // Output monitor and cycle limit
    // ************************************************************

    always @(negedge clk) begin
        if (!rst) begin
            if (due_q.size() != 0 && due_q[0] < cycle) begin
                stop_with_failure($sformatf("result due at cycle %0d never came out", due_q[0]));
            end else if (out_valid) begin
                if (due_q.size() == 0 || due_q[0] != cycle) begin
                    stop_with_failure("out_valid rose with no input two cycles before");
                end else begin
                    check_res("out_res", out_res, exp_q[0]);
                    if (acc_on) mirror_add(exp_q[0]);
                    void'(exp_q.pop_front());
                    void'(due_q.pop_front());
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT)
            stop_with_failure($sformatf("run did not finish within %0d cycles", TIMEOUT));
    end

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        in_valid  = 1'b0;
        in_op     = '0;
        reg_write = 1'b0;
        reg_addr  = '0;
        reg_wdata = '0;
        lfsr      = 32'h168b_42e3;
        acc_on    = 1'b0;
        sum_m     = '0;
        count_m   = '0;
        ovfl_m    = 1'b0;
        for (int i = 0; i < N_TBL; i++) tbl_exp[i] = exp_model(tbl_op[i]);

        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        check_reg("ctrl", ADDR_CTRL, 32'd0);
        write_reg(ADDR_CTRL, 32'd1);
        check_reg("ctrl", ADDR_CTRL, 32'd1);
        write_reg(ADDR_CTRL, 32'd0);
        check_reg("ctrl", ADDR_CTRL, 32'd0);
        check_reg("unmapped", 2'd3, 32'd0);

        // Table with accumulation off
        for (int i = 0; i < N_TBL; i++) send_op(tbl_op[i], tbl_exp[i]);
        finish_stream();
        check_reg("sum", ADDR_SUM, 32'd0);
        check_reg("status", ADDR_STATUS, 32'd0);

        // Back-to-back LFSR burst into the sum
        write_reg(ADDR_CTRL, 32'd1);
        for (int i = 0; i < N_RAND; i++) begin
            op = random_op();
            send_op(op, exp_model(op));
        end
        finish_stream();
        check_reg("sum", ADDR_SUM, sum_m);
        check_reg("status", ADDR_STATUS, {15'd0, ovfl_m, count_m});

        write_reg(ADDR_CTRL, 32'd0);
        for (int i = 0; i < N_IDLE; i++) begin
            op = random_op();
            send_op(op, exp_model(op));
        end
        finish_stream();
        check_reg("sum", ADDR_SUM, sum_m);
        check_reg("status", ADDR_STATUS, {15'd0, ovfl_m, count_m});

        // ************************************************************
        // Clear, then saturate with large inputs
        // ************************************************************

        write_reg(ADDR_SUM, 32'hdead_beef);
        check_reg("sum", ADDR_SUM, 32'd0);
        check_reg("status", ADDR_STATUS, 32'd0);
        write_reg(ADDR_CTRL, 32'd1);
        for (int i = 0; i < N_OVFL; i++) begin
            op = 16'h4200 | 16'(i);
            send_op(op, exp_model(op));
        end
        finish_stream();
        check_reg("sum", ADDR_SUM, 32'hffff_ffff);
        check_reg("status", ADDR_STATUS, {15'd0, 1'b1, 16'(N_OVFL)});
        check_reg("sum", ADDR_SUM, sum_m);
        write_reg(ADDR_SUM, 32'd0);
        check_reg("status", ADDR_STATUS, 32'd0);

        if (u_dut.u_assertions.fail_count == 0) begin
            $display("test passed");
            $finish;
        end else begin
            stop_with_failure("assertion failures were reported during the run");
        end
    end

endmodule

/* vlog.f */
logic/softex_pkg.sv
logic/expu_reg_pkg.sv
logic/expu_schraudolph.sv
logic/expu_regfile.sv
logic/expu_accumulator.sv
logic/expu_top.sv
bench/expu_assertions.sv
bench/expu_tb.sv

/* Bender.yml */
package:
  name: expu

sources:
  # Packages first, then RTL bottom up
  - logic/softex_pkg.sv
  - logic/expu_reg_pkg.sv
  - logic/expu_schraudolph.sv
  - logic/expu_regfile.sv
  - logic/expu_accumulator.sv
  - logic/expu_top.sv

  - target: test
    files:
      - bench/expu_assertions.sv
      - bench/expu_tb.sv
